// File: logic/rv_params.svh
// RV32I core parameters
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define RV_XLEN      32
`define RV_REG_COUNT 32
`define RV_RESET_PC  32'h0000_0000

// major opcodes
`define RV_OP_OP     7'b0110011
`define RV_OP_OP_IMM 7'b0010011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111

// branch conditions
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

// access sizes
`define RV_F3_B  3'b000
`define RV_F3_H  3'b001
`define RV_F3_W  3'b010
`define RV_F3_BU 3'b100
`define RV_F3_HU 3'b101

`endif

// File: logic/rv_pkg.sv
// RV32I core types
`include "rv_params.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;               // data, address or instruction
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;
    typedef logic [2:0] funct3_t;
    typedef logic [`RV_XLEN/8-1:0] strobe_t;            // one bit per byte lane

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE   // undefined opcode
    } inst_fmt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_WAIT_INST,
        ST_EXEC,
        ST_MEM_REQ,
        ST_MEM_WAIT,
        ST_RETIRE
    } core_state_t;

endpackage

// File: logic/decode_if.sv
// decoded instruction bundle
`timescale 1ns/1ps

interface decode_if;
    logic [6:0]        opcode;
    rv_pkg::funct3_t   funct3;
    rv_pkg::reg_idx_t  rs1;
    rv_pkg::reg_idx_t  rs2;
    rv_pkg::reg_idx_t  rd;
    rv_pkg::word_t     imm;
    rv_pkg::inst_fmt_t fmt;
    rv_pkg::alu_op_t   alu_op;
    logic              is_load;
    logic              is_store;
    logic              is_jal;
    logic              is_jalr;
    logic              is_branch;
    logic              writes_rd;

    modport src (output opcode, funct3, rs1, rs2, rd, imm, fmt, alu_op,
                 is_load, is_store, is_jal, is_jalr, is_branch, writes_rd);
    modport exec (input opcode, funct3, imm, fmt, alu_op, is_jal, is_jalr, is_branch);
    modport lsu (input funct3);
    modport ctrl (input is_load, is_store, writes_rd, rd);
endinterface

// File: logic/core_ctrl.sv
// multicycle control, PC and memory sequencing
`timescale 1ns/1ps
`include "rv_params.svh"

module core_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              imem_req_ready,
    input  logic              imem_resp_valid,
    input  rv_pkg::word_t     imem_rdata,
    input  logic              dmem_req_ready,
    input  logic              dmem_resp_valid,
    input  rv_pkg::word_t     dmem_rdata,
    input  rv_pkg::word_t     exec_result,
    input  rv_pkg::word_t     next_pc,
    input  logic              taken,
    input  rv_pkg::word_t     load_data,
    decode_if.ctrl            dec,
    output rv_pkg::word_t     inst,
    output rv_pkg::word_t     pc,
    output logic              imem_req_valid,
    output rv_pkg::word_t     imem_addr,
    output logic              dmem_req_valid,
    output logic              dmem_we,
    output rv_pkg::word_t     dmem_addr,
    output rv_pkg::word_t     load_word,
    output logic              rf_we,
    output rv_pkg::word_t     rf_wdata,
    output logic              retire_valid,
    output rv_pkg::word_t     retire_pc,
    output rv_pkg::reg_idx_t  retire_rd,
    output rv_pkg::word_t     retire_wdata,
    output logic              retire_we
);
    rv_pkg::core_state_t state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= rv_pkg::ST_FETCH;
            pc             <= `RV_RESET_PC;
            imem_req_valid <= 1'b0;
            dmem_req_valid <= 1'b0;
        end else begin
            case (state)
                rv_pkg::ST_FETCH: begin
                    if (imem_req_valid && imem_req_ready) begin
                        imem_req_valid <= 1'b0;
                        state          <= rv_pkg::ST_WAIT_INST;
                    end else begin
                        imem_req_valid <= 1'b1;   // first fetch after reset
                    end
                end
                rv_pkg::ST_WAIT_INST: begin
                    if (imem_resp_valid) state <= rv_pkg::ST_EXEC;
                end
                rv_pkg::ST_EXEC: begin
                    if (dec.is_load || dec.is_store) begin
                        dmem_req_valid <= 1'b1;
                        state          <= rv_pkg::ST_MEM_REQ;
                    end else begin
                        state <= rv_pkg::ST_RETIRE;
                    end
                end
                rv_pkg::ST_MEM_REQ: begin
                    if (dmem_req_valid && dmem_req_ready) begin
                        dmem_req_valid <= 1'b0;
                        state          <= rv_pkg::ST_MEM_WAIT;
                    end
                end
                rv_pkg::ST_MEM_WAIT: begin
                    if (dmem_resp_valid) state <= rv_pkg::ST_RETIRE; // stores complete here too
                end
                rv_pkg::ST_RETIRE: begin
                    pc             <= taken ? next_pc : pc + 32'd4;
                    imem_req_valid <= 1'b1;
                    state          <= rv_pkg::ST_FETCH;
                end
                default: state <= rv_pkg::ST_FETCH;
            endcase
        end
    end

    // instruction, data address and load word
    always_ff @(posedge clk) begin
        if (state == rv_pkg::ST_WAIT_INST && imem_resp_valid) inst <= imem_rdata;
        if (state == rv_pkg::ST_EXEC) begin
            dmem_addr <= exec_result;   // ALU sum is the effective address
            dmem_we   <= dec.is_store;
        end
        if (state == rv_pkg::ST_MEM_WAIT && dmem_resp_valid) load_word <= dmem_rdata;
    end

    assign imem_addr = pc;

    // writeback and retire record
    assign rf_we        = (state == rv_pkg::ST_RETIRE) && dec.writes_rd;
    assign rf_wdata     = dec.is_load ? load_data : exec_result;
    assign retire_valid = (state == rv_pkg::ST_RETIRE);
    assign retire_pc    = pc;
    assign retire_rd    = dec.rd;
    assign retire_we    = rf_we;
    assign retire_wdata = rf_wdata;

endmodule

// File: logic/inst_decoder.sv
// RV32I instruction decoder
`timescale 1ns/1ps
`include "rv_params.svh"

module inst_decoder (
    input  rv_pkg::word_t inst,
    decode_if.src         dec
);
    logic [6:0] opcode;

    assign opcode     = inst[6:0];
    assign dec.opcode = opcode;
    assign dec.funct3 = inst[14:12];
    assign dec.rd     = inst[11:7];
    assign dec.rs1    = inst[19:15];
    assign dec.rs2    = inst[24:20];

    // instruction classes
    assign dec.is_load   = (opcode == `RV_OP_LOAD);
    assign dec.is_store  = (opcode == `RV_OP_STORE);
    assign dec.is_jal    = (opcode == `RV_OP_JAL);
    assign dec.is_jalr   = (opcode == `RV_OP_JALR);
    assign dec.is_branch = (opcode == `RV_OP_BRANCH);

    always_comb begin
        case (opcode)
            `RV_OP_OP:                                   dec.fmt = rv_pkg::FMT_R;
            `RV_OP_OP_IMM, `RV_OP_LOAD, `RV_OP_JALR:     dec.fmt = rv_pkg::FMT_I;
            `RV_OP_STORE:                                dec.fmt = rv_pkg::FMT_S;
            `RV_OP_BRANCH:                               dec.fmt = rv_pkg::FMT_B;
            `RV_OP_LUI, `RV_OP_AUIPC:                    dec.fmt = rv_pkg::FMT_U;
            `RV_OP_JAL:                                  dec.fmt = rv_pkg::FMT_J;
            default:                                     dec.fmt = rv_pkg::FMT_NONE;
        endcase
    end

    always_comb begin
        case (dec.fmt)
            rv_pkg::FMT_I: dec.imm = {{20{inst[31]}}, inst[31:20]};
            rv_pkg::FMT_S: dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_pkg::FMT_B: dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_pkg::FMT_U: dec.imm = {inst[31:12], 12'h000};
            rv_pkg::FMT_J: dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:       dec.imm = '0;
        endcase
    end

    assign dec.writes_rd = (dec.fmt == rv_pkg::FMT_R) || (dec.fmt == rv_pkg::FMT_I) ||
                           (dec.fmt == rv_pkg::FMT_U) || (dec.fmt == rv_pkg::FMT_J);

    // address and link arithmetic all use ADD
    always_comb begin
        dec.alu_op = rv_pkg::ALU_ADD;
        if (opcode == `RV_OP_OP || opcode == `RV_OP_OP_IMM) begin
            case (inst[14:12])
                3'b000: if (opcode == `RV_OP_OP && inst[30]) dec.alu_op = rv_pkg::ALU_SUB;
                3'b001: dec.alu_op = rv_pkg::ALU_SLL;
                3'b010: dec.alu_op = rv_pkg::ALU_SLT;
                3'b011: dec.alu_op = rv_pkg::ALU_SLTU;
                3'b100: dec.alu_op = rv_pkg::ALU_XOR;
                3'b101: dec.alu_op = inst[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL; // funct7[5]
                3'b110: dec.alu_op = rv_pkg::ALU_OR;
                default: dec.alu_op = rv_pkg::ALU_AND;
            endcase
        end
    end

endmodule

// File: logic/reg_file.sv
// integer register file
`timescale 1ns/1ps
`include "rv_params.svh"

module reg_file (
    input  logic             clk,
    input  logic             reset,
    input  logic             we,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::word_t    wdata,
    input  rv_pkg::reg_idx_t raddr1,
    input  rv_pkg::reg_idx_t raddr2,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2
);
    rv_pkg::word_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin   // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: logic/exec_unit.sv
// ALU, branch compare and next PC
`timescale 1ns/1ps
`include "rv_params.svh"

module exec_unit (
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t rs1_data,
    input  rv_pkg::word_t rs2_data,
    decode_if.exec        dec,
    output rv_pkg::word_t result,
    output rv_pkg::word_t next_pc,
    output logic          taken
);
    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t alu_out;
    rv_pkg::word_t pc_plus4;
    logic          branch_cond;

    assign pc_plus4 = pc + 32'd4;

    // operand A: PC-relative forms use the PC, LUI adds to zero
    always_comb begin
        if (dec.opcode == `RV_OP_LUI) begin
            op_a = '0;
        end else if (dec.opcode == `RV_OP_AUIPC || dec.is_jal || dec.is_branch) begin
            op_a = pc;
        end else begin
            op_a = rs1_data;
        end
    end

    assign op_b = (dec.fmt == rv_pkg::FMT_R) ? rs2_data : dec.imm;

    always_comb begin
        case (dec.alu_op)
            rv_pkg::ALU_ADD:  alu_out = op_a + op_b;
            rv_pkg::ALU_SUB:  alu_out = op_a - op_b;
            rv_pkg::ALU_SLL:  alu_out = op_a << op_b[4:0];
            rv_pkg::ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU: alu_out = {31'b0, op_a < op_b};
            rv_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
            rv_pkg::ALU_SRL:  alu_out = op_a >> op_b[4:0];
            rv_pkg::ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
            rv_pkg::ALU_OR:   alu_out = op_a | op_b;
            default:          alu_out = op_a & op_b;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            `RV_F3_BEQ:  branch_cond = (rs1_data == rs2_data);
            `RV_F3_BNE:  branch_cond = (rs1_data != rs2_data);
            `RV_F3_BLT:  branch_cond = ($signed(rs1_data) < $signed(rs2_data));
            `RV_F3_BGE:  branch_cond = ($signed(rs1_data) >= $signed(rs2_data));
            `RV_F3_BLTU: branch_cond = (rs1_data < rs2_data);
            `RV_F3_BGEU: branch_cond = (rs1_data >= rs2_data);
            default:     branch_cond = 1'b0;   // reserved encodings fall through
        endcase
    end

    assign taken = dec.is_jal || dec.is_jalr || (dec.is_branch && branch_cond);

    // jumps write the link address
    assign result = (dec.is_jal || dec.is_jalr) ? pc_plus4 : alu_out;

    always_comb begin
        if (!taken) begin
            next_pc = pc_plus4;
        end else if (dec.is_jalr) begin
            next_pc = {alu_out[31:1], 1'b0};
        end else begin
            next_pc = alu_out;   // pc + imm
        end
    end

endmodule

// File: logic/load_store_unit.sv
// byte lane steering for loads and stores
`timescale 1ns/1ps
`include "rv_params.svh"

module load_store_unit (
    input  rv_pkg::word_t   addr,
    input  rv_pkg::word_t   store_data,
    input  rv_pkg::word_t   load_word,
    decode_if.lsu           dec,
    output rv_pkg::strobe_t wstrb,
    output rv_pkg::word_t   wdata,
    output rv_pkg::word_t   load_data
);
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // store side
    always_comb begin
        case (dec.funct3)
            `RV_F3_B: begin
                wstrb = 4'b0001 << addr[1:0];
                wdata = {4{store_data[7:0]}};
            end
            `RV_F3_H: begin
                wstrb = addr[1] ? 4'b1100 : 4'b0011;
                wdata = {2{store_data[15:0]}};
            end
            `RV_F3_W: begin
                wstrb = 4'b1111;
                wdata = store_data;
            end
            default: begin
                wstrb = 4'b0000;    // no lanes for undefined sizes
                wdata = store_data;
            end
        endcase
    end

    // load side
    assign lane_byte = load_word[{addr[1:0], 3'b000} +: 8];
    assign lane_half = load_word[{addr[1], 4'b0000} +: 16];

    always_comb begin
        case (dec.funct3)
            `RV_F3_B:  load_data = {{24{lane_byte[7]}}, lane_byte};
            `RV_F3_H:  load_data = {{16{lane_half[15]}}, lane_half};
            `RV_F3_BU: load_data = {24'b0, lane_byte};
            `RV_F3_HU: load_data = {16'b0, lane_half};
            default:   load_data = load_word;   // LW
        endcase
    end

endmodule

// File: logic/rv_core_top.sv
// RV32I multicycle core
`timescale 1ns/1ps

module rv_core_top (
    input  logic              clk,
    input  logic              reset,
    output logic              imem_req_valid,
    input  logic              imem_req_ready,
    output rv_pkg::word_t     imem_addr,
    input  logic              imem_resp_valid,
    input  rv_pkg::word_t     imem_rdata,
    output logic              dmem_req_valid,
    input  logic              dmem_req_ready,
    output logic              dmem_we,
    output rv_pkg::word_t     dmem_addr,
    output rv_pkg::strobe_t   dmem_wstrb,
    output rv_pkg::word_t     dmem_wdata,
    input  logic              dmem_resp_valid,
    input  rv_pkg::word_t     dmem_rdata,
    output logic              retire_valid,
    output rv_pkg::word_t     retire_pc,
    output logic              retire_we,
    output rv_pkg::reg_idx_t  retire_rd,
    output rv_pkg::word_t     retire_wdata
);
    decode_if dec_bus ();

    rv_pkg::word_t inst;
    rv_pkg::word_t pc;
    rv_pkg::word_t rs1_data;
    rv_pkg::word_t rs2_data;
    rv_pkg::word_t exec_result;
    rv_pkg::word_t next_pc;
    logic          taken;
    rv_pkg::word_t load_word;
    rv_pkg::word_t load_data;
    logic          rf_we;
    rv_pkg::word_t rf_wdata;

    core_ctrl u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .imem_req_ready  (imem_req_ready),
        .imem_resp_valid (imem_resp_valid),
        .imem_rdata      (imem_rdata),
        .dmem_req_ready  (dmem_req_ready),
        .dmem_resp_valid (dmem_resp_valid),
        .dmem_rdata      (dmem_rdata),
        .exec_result     (exec_result),
        .next_pc         (next_pc),
        .taken           (taken),
        .load_data       (load_data),
        .dec             (dec_bus.ctrl),
        .inst            (inst),
        .pc              (pc),
        .imem_req_valid  (imem_req_valid),
        .imem_addr       (imem_addr),
        .dmem_req_valid  (dmem_req_valid),
        .dmem_we         (dmem_we),
        .dmem_addr       (dmem_addr),
        .load_word       (load_word),
        .rf_we           (rf_we),
        .rf_wdata        (rf_wdata),
        .retire_valid    (retire_valid),
        .retire_pc       (retire_pc),
        .retire_rd       (retire_rd),
        .retire_wdata    (retire_wdata),
        .retire_we       (retire_we)
    );

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (dec_bus.src)
    );

    reg_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .we     (rf_we),
        .waddr  (dec_bus.rd),
        .wdata  (rf_wdata),
        .raddr1 (dec_bus.rs1),
        .raddr2 (dec_bus.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    exec_unit u_exec (
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dec      (dec_bus.exec),
        .result   (exec_result),
        .next_pc  (next_pc),
        .taken    (taken)
    );

    load_store_unit u_lsu (
        .addr       (dmem_addr),
        .store_data (rs2_data),
        .load_word  (load_word),
        .dec        (dec_bus.lsu),
        .wstrb      (dmem_wstrb),
        .wdata      (dmem_wdata),
        .load_data  (load_data)
    );

endmodule

// File: tb/tb_rv_core.sv
// RV32I core testbench
`timescale 1ns/1ps

module tb_rv_core;
    localparam int DATA_BASE = 'h80;
    localparam int EXP_BASE  = 'h90;
    localparam int COUNT_IDX = 'hA0;
    localparam int REC_BASE  = 'hA1;

    logic        clk;
    logic        reset;
    logic        imem_req_valid, imem_req_ready, imem_resp_valid;
    logic [31:0] imem_addr, imem_rdata;
    logic        dmem_req_valid, dmem_req_ready, dmem_we, dmem_resp_valid;
    logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
    logic [3:0]  dmem_wstrb;
    logic        retire_valid, retire_we;
    logic [31:0] retire_pc, retire_wdata;
    logic [4:0]  retire_rd;

    logic [31:0] golden [0:511];
    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:3];     // words at 0x100..0x10c
    logic [15:0] lfsr;
    logic        ipend, dpend;
    logic [1:0]  iwait, dwait;
    logic [31:0] iaddr, drd;
    int rec_count, rec_idx, checks, errors;
    int cur_group, grp_checks, grp_fails;

    rv_core_top dut (.*);

    always #2 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [3:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic int group_of(input logic [31:0] pc);
        if (pc < 32'h38) return 0;
        if (pc < 32'h80) return 1;
        if (pc < 32'h98) return 2;
        return 3;
    endfunction

    function automatic string group_name(input int g);
        case (g)
            0:       return "alu and upper immediate";
            1:       return "branches";
            2:       return "jumps";
            default: return "loads and stores";
        endcase
    endfunction

    task automatic report_group();
        $display("test %s: %0d checks, %0d failed",
                 group_name(cur_group), grp_checks, grp_fails);
    endtask

    // memory models with random ready and response delay
    always @(posedge clk) begin : mem_models
        logic [3:0] r;
        if (reset) begin
            imem_req_ready  <= 1'b0;
            imem_resp_valid <= 1'b0;
            dmem_req_ready  <= 1'b0;
            dmem_resp_valid <= 1'b0;
            ipend           <= 1'b0;
            dpend           <= 1'b0;
        end else begin
            imem_resp_valid <= 1'b0;
            if (ipend) begin
                if (iwait == 0) begin
                    imem_resp_valid <= 1'b1;
                    imem_rdata      <= imem[iaddr[7:2]];
                    ipend           <= 1'b0;
                end else begin
                    iwait <= iwait - 2'd1;
                end
            end else if (imem_req_valid && imem_req_ready) begin
                draw_bits(2, r);
                ipend <= 1'b1;
                iwait <= r[1:0];
                iaddr <= imem_addr;
            end
            draw_bits(1, r);
            imem_req_ready <= r[0];

            dmem_resp_valid <= 1'b0;
            if (dpend) begin
                if (dwait == 0) begin
                    dmem_resp_valid <= 1'b1;
                    dmem_rdata      <= drd;
                    dpend           <= 1'b0;
                end else begin
                    dwait <= dwait - 2'd1;
                end
            end else if (dmem_req_valid && dmem_req_ready) begin
                draw_bits(2, r);
                dpend <= 1'b1;
                dwait <= r[1:0];
                drd   <= dmem[dmem_addr[3:2]];
                if (dmem_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (dmem_wstrb[b]) dmem[dmem_addr[3:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
                    end
                end
            end
            draw_bits(1, r);
            dmem_req_ready <= r[0];
        end
    end

    // compare each retire pulse with the next record
    always @(posedge clk) begin : retire_check
        logic [31:0] e_pc, e_we, e_rd, e_wd;
        int g;
        if (!reset && retire_valid && rec_idx < rec_count) begin
            e_pc = golden[REC_BASE + 4*rec_idx];
            e_we = golden[REC_BASE + 4*rec_idx + 1];
            e_rd = golden[REC_BASE + 4*rec_idx + 2];
            e_wd = golden[REC_BASE + 4*rec_idx + 3];
            g = group_of(e_pc);
            if (g != cur_group) begin
                if (cur_group >= 0) report_group();
                cur_group  = g;
                grp_checks = 0;
                grp_fails  = 0;
            end
            checks++;
            grp_checks++;
            assert (retire_pc == e_pc && retire_we == e_we[0] &&
                    (!e_we[0] || (retire_rd == e_rd[4:0] && retire_wdata == e_wd))) else begin
                $write("[FAIL] %0t: retire %0d expected pc %h we %0d rd %0d data %h",
                       $time, rec_idx, e_pc, e_we[0], e_rd, e_wd);
                $display(", got pc %h we %0d rd %0d data %h",
                         retire_pc, retire_we, retire_rd, retire_wdata);
                errors++;
                grp_fails++;
            end
            rec_idx++;
        end
    end

    initial begin
        int dfails;
        clk       = 1'b0;
        reset     <= 1'b1;
        imem_req_ready  <= 1'b0;
        imem_resp_valid <= 1'b0;
        imem_rdata      <= '0;
        dmem_req_ready  <= 1'b0;
        dmem_resp_valid <= 1'b0;
        dmem_rdata      <= '0;
        lfsr      = 16'd46385;
        rec_idx   = 0;
        checks    = 0;
        errors    = 0;
        cur_group = -1;
        dfails    = 0;
        $readmemh("tb/rv_golden.mem", golden);
        for (int i = 0; i < 64; i++) imem[i] = golden[i];
        for (int i = 0; i < 4; i++) dmem[i] = golden[DATA_BASE + i];
        rec_count = golden[COUNT_IDX];

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        wait (rec_idx == rec_count);
        @(posedge clk);
        report_group();

        // final data memory image
        for (int i = 0; i < 4; i++) begin
            checks++;
            assert (dmem[i] == golden[EXP_BASE + i]) else begin
                $display("[FAIL] %0t: data word %h expected %h, got %h",
                         $time, 32'h100 + 4*i, golden[EXP_BASE + i], dmem[i]);
                errors++;
                dfails++;
            end
        end
        $display("test final data image: 4 checks, %0d failed", dfails);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog scaled by program length
    initial begin
        #1;
        repeat (rec_count * 64) @(posedge clk);
        $display("watchdog: core stalled, only %0d of %0d instructions retired",
                 rec_idx, rec_count);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+logic
logic/rv_pkg.sv
logic/decode_if.sv
logic/core_ctrl.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/load_store_unit.sv
logic/rv_core_top.sv
tb/tb_rv_core.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_rv_core
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard logic/*.sv logic/*.svh tb/*.sv)

.PHONY: all run check clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN) tb/rv_golden.mem
	$(BIN) > $(LOG) ; cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

check:
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/rv_golden.mem
// @000 program words, @080 data words at 0x100, @090 final data image
// @0A0 record count, then records of four words: pc we rd wdata
@000
00500093 FFD00113 002081B3 40208233 001122B3 00113333 0FF0C393 40115413
01C15493 00309513 00108013 001065B3 12345637 00001697 00108463 00000093
00109463 00114463 00000093 00115463 0020E463 00000093 0020F463 00208463
00209463 00000093 0020C463 0020D463 00000093 00116463 00117463 00000093
0080076F 00000093 09900793 00078867 00000093 00000093 10000893 87654937
32190913 0128A023 007882A3 00289523 0008A983 00588A03 0058CA83 00A89B03
00A8DB83 00388C03 0088DC83 0000006F
@080
DEADBEEF 11223344 55667788 CAFEF00D
@090
87654321 1122FA44 FFFD7788 CAFEF00D
@0A0
0000002B
// ALU, x0 write, LUI and AUIPC
00000000 1 01 00000005  00000004 1 02 FFFFFFFD
00000008 1 03 00000002  0000000C 1 04 00000008
00000010 1 05 00000001  00000014 1 06 00000000
00000018 1 07 000000FA  0000001C 1 08 FFFFFFFE
00000020 1 09 0000000F  00000024 1 0A 00000028
00000028 1 00 00000006  0000002C 1 0B 00000005
00000030 1 0C 12345000  00000034 1 0D 00001034
// branches taken and not taken
00000038 0 00 00000000  00000040 0 00 00000000
00000044 0 00 00000000  0000004C 0 00 00000000
00000050 0 00 00000000  00000058 0 00 00000000
0000005C 0 00 00000000  00000060 0 00 00000000
00000068 0 00 00000000  0000006C 0 00 00000000
00000074 0 00 00000000  00000078 0 00 00000000
// jumps
00000080 1 0E 00000084  00000088 1 0F 00000099
0000008C 1 10 00000090
// loads and stores
00000098 1 11 00000100  0000009C 1 12 87654000
000000A0 1 12 87654321  000000A4 0 00 00000000
000000A8 0 00 00000000  000000AC 0 00 00000000
000000B0 1 13 87654321  000000B4 1 14 FFFFFFFA
000000B8 1 15 000000FA  000000BC 1 16 FFFFFFFD
000000C0 1 17 0000FFFD  000000C4 1 18 FFFFFF87
000000C8 1 19 00007788  000000CC 1 00 000000D0
